/* src/ooo_decode_pkg.sv */
package ooo_decode_pkg;

  // datapath widths
  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;
  // funct3 with instr[30] on top
  localparam int OP_W       = 4;

  // rv32 major opcodes handled by this stage
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_t;

  typedef enum logic [1:0] {
    FU_ARITH = 2'd0,
    FU_MUL   = 2'd1,
    FU_DIV   = 2'd2,
    FU_LS    = 2'd3
  } fu_type_t;

  typedef enum logic {
    SRC_A_RS1 = 1'b0,
    SRC_A_PC  = 1'b1
  } src_a_sel_t;

  // imm_i also covers the shift amount
  typedef enum logic [1:0] {
    SRC_B_RS2   = 2'd0,
    SRC_B_IMM_I = 2'd1,
    SRC_B_IMM_S = 2'd2,
    SRC_B_IMM_U = 2'd3
  } src_b_sel_t;

  // write-back port reservation table
  localparam int WB_SLOTS = 18;
  localparam int SLOT_W   = $clog2(WB_SLOTS);

  // cycles from issue to write-back per unit
  localparam int SLOT_ARITH    = 0;
  localparam int SLOT_MUL      = 3;
  localparam int SLOT_DIV      = 17;
  localparam int SLOT_DIV_FAST = 0;

endpackage

/* src/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
  import ooo_decode_pkg::*;
(
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  in_valid,
  input  logic                  flush,
  input  logic [WORD_W-1:0]     instr,
  input  logic [WORD_W-1:0]     pc,
  input  logic [WORD_W-1:0]     rs1_data,
  input  logic [WORD_W-1:0]     rs2_data,
  output logic                  dec_valid,
  output logic [WORD_W-1:0]     dec_instr,
  output logic [WORD_W-1:0]     dec_pc,
  output logic [WORD_W-1:0]     dec_rs1,
  output logic [WORD_W-1:0]     dec_rs2,
  output fu_type_t              fu_type,
  output src_a_sel_t            src_a_sel,
  output src_b_sel_t            src_b_sel,
  output logic [OP_W-1:0]       op,
  output logic [REG_ADDR_W-1:0] rd,
  output logic                  is_load,
  output logic                  is_store
);

  opcode_t                 opcode;
  logic [2:0]              funct3;
  logic                    supported;
  logic                    zero_rs1;
  logic                    is_shift;
  fu_type_t                next_fu;
  src_a_sel_t              next_a_sel;
  src_b_sel_t              next_b_sel;
  logic [OP_W-1:0]         next_op;
  logic [REG_ADDR_W-1:0]   next_rd;
  logic                    next_load;
  logic                    next_store;

  assign opcode   = opcode_t'(instr[6:0]);
  assign funct3   = instr[14:12];
  // slli / srli / srai
  assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

  always_comb begin
    supported  = 1'b1;
    zero_rs1   = 1'b0;
    next_fu    = FU_ARITH;
    next_a_sel = SRC_A_RS1;
    next_b_sel = SRC_B_RS2;
    next_op    = {1'b0, funct3};
    next_rd    = instr[11:7];
    next_load  = 1'b0;
    next_store = 1'b0;
    case (opcode)
      OP: begin
        // funct7 == 1 selects the M extension
        if (instr[31:25] == 7'b0000001) begin
          next_fu = funct3[2] ? FU_DIV : FU_MUL;
        end else begin
          next_op = {instr[30], funct3};
        end
      end
      OP_IMM: begin
        next_b_sel = SRC_B_IMM_I;
        next_op    = {is_shift & instr[30], funct3};
      end
      LUI: begin
        // add of zero and the upper immediate
        zero_rs1   = 1'b1;
        next_b_sel = SRC_B_IMM_U;
        next_op    = '0;
      end
      AUIPC: begin
        next_a_sel = SRC_A_PC;
        next_b_sel = SRC_B_IMM_U;
        next_op    = '0;
      end
      LOAD: begin
        next_fu    = FU_LS;
        next_b_sel = SRC_B_IMM_I;
        next_load  = 1'b1;
      end
      STORE: begin
        next_fu    = FU_LS;
        next_b_sel = SRC_B_IMM_S;
        next_rd    = '0;
        next_store = 1'b1;
      end
      default: supported = 1'b0;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= in_valid & supported & ~flush;
    end
  end

  // decoded payload, qualified by dec_valid
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      dec_instr <= instr;
      dec_pc    <= pc;
      dec_rs1   <= zero_rs1 ? '0 : rs1_data;
      dec_rs2   <= rs2_data;
      fu_type   <= next_fu;
      src_a_sel <= next_a_sel;
      src_b_sel <= next_b_sel;
      op        <= next_op;
      rd        <= next_rd;
      is_load   <= next_load;
      is_store  <= next_store;
    end
  end

endmodule

/* src/operand_select.sv */
`timescale 1ns/1ps

module operand_select
  import ooo_decode_pkg::*;
(
  input  logic [WORD_W-1:0] dec_instr,
  input  logic [WORD_W-1:0] dec_pc,
  input  logic [WORD_W-1:0] dec_rs1,
  input  logic [WORD_W-1:0] dec_rs2,
  input  src_a_sel_t        src_a_sel,
  input  src_b_sel_t        src_b_sel,
  output logic [WORD_W-1:0] source_a,
  output logic [WORD_W-1:0] source_b,
  output logic [WORD_W-1:0] store_data
);

  logic [WORD_W-1:0] imm_i_ext;
  logic [WORD_W-1:0] imm_s_ext;
  logic [WORD_W-1:0] imm_u;
  logic [WORD_W-1:0] shamt;
  logic [WORD_W-1:0] imm_or_shamt;
  logic              shift_imm;

  // sign extended immediates
  assign imm_i_ext = {{(WORD_W-12){dec_instr[31]}}, dec_instr[31:20]};
  assign imm_s_ext = {{(WORD_W-12){dec_instr[31]}}, dec_instr[31:25], dec_instr[11:7]};
  assign imm_u     = {dec_instr[31:12], 12'b0};
  assign shamt     = {{(WORD_W-5){1'b0}}, dec_instr[24:20]};

  // shift-immediate forms carry funct7 in the upper bits
  assign shift_imm = (dec_instr[6:0] == OP_IMM) &&
                     ((dec_instr[14:12] == 3'b001) || (dec_instr[14:12] == 3'b101));
  assign imm_or_shamt = shift_imm ? shamt : imm_i_ext;

  always_comb begin
    case (src_a_sel)
      SRC_A_PC: source_a = dec_pc;
      default:  source_a = dec_rs1;
    endcase
  end

  always_comb begin
    case (src_b_sel)
      SRC_B_IMM_I: source_b = imm_or_shamt;
      SRC_B_IMM_S: source_b = imm_s_ext;
      SRC_B_IMM_U: source_b = imm_u;
      default:     source_b = dec_rs2;
    endcase
  end

  assign store_data = dec_rs2;

endmodule

/* src/wb_slot_tracker.sv */
`timescale 1ns/1ps

module wb_slot_tracker
  import ooo_decode_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  input  logic              dec_valid,
  input  logic              flush,
  input  fu_type_t          fu_type,
  input  logic [WORD_W-1:0] source_a,
  input  logic [WORD_W-1:0] source_b,
  output logic              conflict
);

  logic [WB_SLOTS-1:0] resv_q;
  logic [WB_SLOTS-1:0] resv_next;
  logic [SLOT_W-1:0]   slot;
  logic                has_slot;
  logic                div_fast;

  // overflow and divide by zero finish early
  assign div_fast = (source_a == {1'b1, {(WORD_W-1){1'b0}}}) ||
                    (source_b == '0) || (source_b == '1);

  always_comb begin
    has_slot = 1'b1;
    case (fu_type)
      FU_ARITH: slot = SLOT_W'(SLOT_ARITH);
      FU_MUL:   slot = SLOT_W'(SLOT_MUL);
      FU_DIV:   slot = div_fast ? SLOT_W'(SLOT_DIV_FAST) : SLOT_W'(SLOT_DIV);
      default: begin
        // load/store has its own write-back path
        slot     = '0;
        has_slot = 1'b0;
      end
    endcase
  end

  assign conflict = dec_valid & has_slot & resv_q[slot];

  always_comb begin
    resv_next = resv_q;
    if (dec_valid && !flush && has_slot && !resv_q[slot]) begin
      resv_next[slot] = 1'b1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      resv_q <= '0;
    end else begin
      resv_q <= resv_next >> 1;
    end
  end

endmodule

/* src/issue_latch.sv */
`timescale 1ns/1ps

module issue_latch
  import ooo_decode_pkg::*;
(
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  dec_valid,
  input  logic                  flush,
  input  logic                  conflict,
  input  logic                  is_load,
  input  logic                  is_store,
  input  fu_type_t              fu_type,
  input  logic [WORD_W-1:0]     source_a,
  input  logic [WORD_W-1:0]     source_b,
  input  logic [WORD_W-1:0]     store_data,
  input  logic [WORD_W-1:0]     dec_pc,
  input  logic [OP_W-1:0]       op,
  input  logic [REG_ADDR_W-1:0] rd,
  output logic                  arith_valid,
  output logic                  mul_valid,
  output logic                  div_valid,
  output logic                  ls_valid,
  output logic                  replay,
  output logic                  ls_load,
  output logic                  ls_store,
  output logic [WORD_W-1:0]     port_a,
  output logic [WORD_W-1:0]     port_b,
  output logic [WORD_W-1:0]     st_data,
  output logic [WORD_W-1:0]     issue_pc,
  output logic [OP_W-1:0]       issue_op,
  output logic [REG_ADDR_W-1:0] issue_rd
);

  logic live;
  logic issue;

  assign live  = dec_valid & ~flush;
  assign issue = live & ~conflict;

  // one-cycle strobes
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      arith_valid <= 1'b0;
      mul_valid   <= 1'b0;
      div_valid   <= 1'b0;
      ls_valid    <= 1'b0;
      replay      <= 1'b0;
    end else begin
      arith_valid <= issue && (fu_type == FU_ARITH);
      mul_valid   <= issue && (fu_type == FU_MUL);
      div_valid   <= issue && (fu_type == FU_DIV);
      ls_valid    <= issue && (fu_type == FU_LS);
      replay      <= live & conflict;
    end
  end

  // payload only moves on an issue
  always_ff @(posedge CLK) begin
    if (issue) begin
      ls_load  <= is_load;
      ls_store <= is_store;
      port_a   <= source_a;
      port_b   <= source_b;
      st_data  <= store_data;
      issue_pc <= dec_pc;
      issue_op <= op;
      issue_rd <= rd;
    end
  end

endmodule

/* src/ooo_decode_stage.sv */
`timescale 1ns/1ps

module ooo_decode_stage
  import ooo_decode_pkg::*;
(
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  in_valid,
  input  logic                  flush,
  input  logic [WORD_W-1:0]     instr,
  input  logic [WORD_W-1:0]     pc,
  input  logic [WORD_W-1:0]     rs1_data,
  input  logic [WORD_W-1:0]     rs2_data,
  output logic                  arith_valid,
  output logic                  mul_valid,
  output logic                  div_valid,
  output logic                  ls_valid,
  output logic                  replay,
  output logic                  ls_load,
  output logic                  ls_store,
  output logic [WORD_W-1:0]     port_a,
  output logic [WORD_W-1:0]     port_b,
  output logic [WORD_W-1:0]     st_data,
  output logic [WORD_W-1:0]     issue_pc,
  output logic [OP_W-1:0]       issue_op,
  output logic [REG_ADDR_W-1:0] issue_rd
);

  // stage 1 to stage 2
  logic                  dec_valid;
  logic [WORD_W-1:0]     dec_instr;
  logic [WORD_W-1:0]     dec_pc;
  logic [WORD_W-1:0]     dec_rs1;
  logic [WORD_W-1:0]     dec_rs2;
  fu_type_t              fu_type;
  src_a_sel_t            src_a_sel;
  src_b_sel_t            src_b_sel;
  logic [OP_W-1:0]       op;
  logic [REG_ADDR_W-1:0] rd;
  logic                  is_load;
  logic                  is_store;

  // stage 2 internals
  logic [WORD_W-1:0]     source_a;
  logic [WORD_W-1:0]     source_b;
  logic [WORD_W-1:0]     store_data;
  logic                  conflict;

  instr_decoder u_decoder (
    .CLK       (CLK),
    .nRST      (nRST),
    .in_valid  (in_valid),
    .flush     (flush),
    .instr     (instr),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .dec_valid (dec_valid),
    .dec_instr (dec_instr),
    .dec_pc    (dec_pc),
    .dec_rs1   (dec_rs1),
    .dec_rs2   (dec_rs2),
    .fu_type   (fu_type),
    .src_a_sel (src_a_sel),
    .src_b_sel (src_b_sel),
    .op        (op),
    .rd        (rd),
    .is_load   (is_load),
    .is_store  (is_store)
  );

  operand_select u_operands (
    .dec_instr  (dec_instr),
    .dec_pc     (dec_pc),
    .dec_rs1    (dec_rs1),
    .dec_rs2    (dec_rs2),
    .src_a_sel  (src_a_sel),
    .src_b_sel  (src_b_sel),
    .source_a   (source_a),
    .source_b   (source_b),
    .store_data (store_data)
  );

  wb_slot_tracker u_wb_slots (
    .CLK       (CLK),
    .nRST      (nRST),
    .dec_valid (dec_valid),
    .flush     (flush),
    .fu_type   (fu_type),
    .source_a  (source_a),
    .source_b  (source_b),
    .conflict  (conflict)
  );

  issue_latch u_issue (
    .CLK         (CLK),
    .nRST        (nRST),
    .dec_valid   (dec_valid),
    .flush       (flush),
    .conflict    (conflict),
    .is_load     (is_load),
    .is_store    (is_store),
    .fu_type     (fu_type),
    .source_a    (source_a),
    .source_b    (source_b),
    .store_data  (store_data),
    .dec_pc      (dec_pc),
    .op          (op),
    .rd          (rd),
    .arith_valid (arith_valid),
    .mul_valid   (mul_valid),
    .div_valid   (div_valid),
    .ls_valid    (ls_valid),
    .replay      (replay),
    .ls_load     (ls_load),
    .ls_store    (ls_store),
    .port_a      (port_a),
    .port_b      (port_b),
    .st_data     (st_data),
    .issue_pc    (issue_pc),
    .issue_op    (issue_op),
    .issue_rd    (issue_rd)
  );

endmodule

/* testbench/tb_ooo_decode.sv */
`timescale 1ns/1ps

module tb_ooo_decode
  import ooo_decode_pkg::*;
();

  // unit column codes of the pattern file
  localparam int UNIT_NONE   = 0;
  localparam int UNIT_ARITH  = 1;
  localparam int UNIT_MUL    = 2;
  localparam int UNIT_DIV    = 3;
  localparam int UNIT_LOAD   = 4;
  localparam int UNIT_STORE  = 5;
  localparam int UNIT_REPLAY = 6;

  typedef struct packed {
    logic [31:0] idle;
    logic [31:0] flush;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] unit;
    logic [31:0] port_a;
    logic [31:0] port_b;
    logic [31:0] rd;
    logic [31:0] op;
  } row_t;

  logic                  CLK;
  logic                  nRST;
  logic                  in_valid;
  logic                  flush;
  logic [WORD_W-1:0]     instr;
  logic [WORD_W-1:0]     pc;
  logic [WORD_W-1:0]     rs1_data;
  logic [WORD_W-1:0]     rs2_data;
  logic                  arith_valid;
  logic                  mul_valid;
  logic                  div_valid;
  logic                  ls_valid;
  logic                  replay;
  logic                  ls_load;
  logic                  ls_store;
  logic [WORD_W-1:0]     port_a;
  logic [WORD_W-1:0]     port_b;
  logic [WORD_W-1:0]     st_data;
  logic [WORD_W-1:0]     issue_pc;
  logic [OP_W-1:0]       issue_op;
  logic [REG_ADDR_W-1:0] issue_rd;

  row_t rows[$];
  row_t idle_row;
  // expectations for the rows driven one and two cycles back
  row_t exp_mid;
  row_t exp_old;
  int   cycle_limit = 0;
  int   cycle_count = 0;

  ooo_decode_stage DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Some tests failed");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got %h, expected %h", name, actual, expected);
      $display("Some tests failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_issue(input row_t r);
    logic issued;
    logic is_ls;
    issued = (r.unit >= UNIT_ARITH) && (r.unit <= UNIT_STORE);
    is_ls  = (r.unit == UNIT_LOAD) || (r.unit == UNIT_STORE);
    check_val("arith_valid", 32'(arith_valid), 32'(r.unit == UNIT_ARITH));
    check_val("mul_valid", 32'(mul_valid), 32'(r.unit == UNIT_MUL));
    check_val("div_valid", 32'(div_valid), 32'(r.unit == UNIT_DIV));
    check_val("ls_valid", 32'(ls_valid), 32'(is_ls));
    check_val("replay", 32'(replay), 32'(r.unit == UNIT_REPLAY));
    if (issued) begin
      check_val("port_a", port_a, r.port_a);
      check_val("port_b", port_b, r.port_b);
      check_val("issue_pc", issue_pc, r.pc);
      check_val("issue_rd", 32'(issue_rd), r.rd);
      check_val("issue_op", 32'(issue_op), r.op);
    end
    if (is_ls) begin
      check_val("ls_load", 32'(ls_load), 32'(r.unit == UNIT_LOAD));
      check_val("ls_store", 32'(ls_store), 32'(r.unit == UNIT_STORE));
      // store data is the rs2 value as supplied
      check_val("st_data", st_data, r.rs2);
    end
  endtask

  // outputs at this falling edge belong to the row driven two edges back
  task automatic drive_cycle(input row_t r, input logic valid);
    @(negedge CLK);
    check_issue(exp_old);
    exp_old  = exp_mid;
    exp_mid  = r;
    in_valid = valid;
    flush    = valid & r.flush[0];
    instr    = r.instr;
    pc       = r.pc;
    rs1_data = r.rs1;
    rs2_data = r.rs2;
  endtask

  initial begin
    int    fd;
    int    fields;
    string line;
    row_t  r;
    nRST     = 1'b0;
    in_valid = 1'b0;
    flush    = 1'b0;
    instr    = '0;
    pc       = '0;
    rs1_data = '0;
    rs2_data = '0;
    idle_row = '0;
    exp_mid  = '0;
    exp_old  = '0;
    void'($urandom(28));
    fd = $fopen("testbench/ooo_decode_patterns.txt", "r");
    if (fd == 0) begin
      $display("Some tests failed");
      $fatal(1, "could not open the pattern file");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        r = '0;
        fields = $sscanf(line, "%d %d %h %h %h %h %d %h %h %d %h", r.idle, r.flush,
                         r.instr, r.pc, r.rs1, r.rs2, r.unit, r.port_a, r.port_b,
                         r.rd, r.op);
        if (fields != 11) begin
          $display("Some tests failed");
          $fatal(1, "a pattern row could not be parsed");
        end
        // lui ignores both register values
        if (r.instr[6:0] == LUI) begin
          r.rs1 = $urandom;
          r.rs2 = $urandom;
        end
        rows.push_back(r);
      end
    end
    $fclose(fd);
    cycle_limit = 50;
    foreach (rows[i]) cycle_limit += int'(rows[i].idle) + 3;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    foreach (rows[i]) begin
      repeat (rows[i].idle) drive_cycle(idle_row, 1'b0);
      drive_cycle(rows[i], 1'b1);
    end
    // empty both stages
    repeat (2) drive_cycle(idle_row, 1'b0);
    $display("All tests passed");
    $finish;
  end

endmodule

/* testbench/ooo_decode_patterns.txt */
# idle flush instr pc rs1 rs2 unit port_a port_b rd op (idle flush unit rd decimal, others hex)
# unit 0 none, 1 arith, 2 mul, 3 div, 4 load, 5 store, 6 replay
# a row followed at once by a flush row expects none
2 0 002081b3 00001000 11111111 22222222 1 11111111 22222222 3 0
0 0 40208233 00001004 00000005 00000007 1 00000005 00000007 4 8
0 0 80030293 00001008 00001000 00000000 1 00001000 fffff800 5 0
0 0 12300393 0000100c 00000000 00000000 1 00000000 00000123 7 0
0 0 4074d413 00001010 80000000 00000000 1 80000000 00000007 8 d
0 0 01f59513 00001014 00000001 00000000 1 00000001 0000001f 10 1
0 0 abcde637 00001018 00000000 00000000 1 00000000 abcde000 12 0
0 0 fffff697 0000101c 00000000 00000000 1 0000101c fffff000 13 0
1 0 9f87a703 00001020 20000000 0badf00d 4 20000000 fffff9f8 14 2
0 0 8708ae23 00001024 30000000 cafef00d 5 30000000 fffff87c 0 2
2 0 03498933 00001028 00000003 00000004 2 00000003 00000004 18 0
0 0 037b3ab3 0000102c 00000007 00000009 2 00000007 00000009 21 3
1 0 003100b3 00001030 00000001 00000002 6 00000000 00000000 0 0
0 0 003100b3 00001034 00000001 00000002 6 00000000 00000000 0 0
0 0 003100b3 00001038 00000001 00000002 1 00000001 00000002 1 0
2 0 027342b3 0000103c 00000064 00000007 3 00000064 00000007 5 4
0 0 02a4d433 00001040 00000010 00000000 3 00000010 00000000 8 5
0 0 003100b3 00001044 00000001 00000002 1 00000001 00000002 1 0
11 0 03498933 00001048 00000003 00000004 6 00000000 00000000 0 0
2 0 003100b3 0000104c 00000001 00000002 6 00000000 00000000 0 0
0 0 003100b3 00001050 00000001 00000002 1 00000001 00000002 1 0
2 0 002081b3 00001054 11111111 22222222 0 00000000 00000000 0 0
0 1 40208233 00001058 00000005 00000007 0 00000000 00000000 0 0
0 0 0000006f 0000105c 00000000 00000000 0 00000000 00000000 0 0
0 0 002081b3 00001060 11111111 22222222 1 11111111 22222222 3 0
0 0 03498933 00001064 00000003 00000004 2 00000003 00000004 18 0
1 0 02b564b3 00001068 80000000 00000003 3 80000000 00000003 9 6
16 0 003100b3 0000106c 00000001 00000002 1 00000001 00000002 1 0

/* ooo_decode.f */
src/ooo_decode_pkg.sv
src/instr_decoder.sv
src/operand_select.sv
src/wb_slot_tracker.sv
src/issue_latch.sv
src/ooo_decode_stage.sv
testbench/tb_ooo_decode.sv

/* run_sim.sh */
#!/bin/sh
# build the ooo_decode testbench with verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --top-module tb_ooo_decode \
  -f ooo_decode.f \
  -o sim_ooo_decode

# a $fatal in the testbench gives a failing exit status
./obj_dir/sim_ooo_decode
